// ==== source/uart_pkg.sv ====
package uart_pkg;

  // Start, eight data bits, parity and stop.
  localparam int FRAME_BITS = 11;
  localparam int DATA_BITS  = 8;

  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT  = 1'b1;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 parity;
  } uart_frame_t;

  // Taken from bit 15 of the command word.
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } cmd_op_e;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_SEND_HI = 3'd1,
    ST_SEND_LO = 3'd2,
    ST_WAIT_RX = 3'd3,
    ST_DONE    = 3'd4
  } ctrl_state_e;

  // Odd parity over the data byte.
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    return ~^data;
  endfunction

  function automatic uart_frame_t make_frame(input logic [DATA_BITS-1:0] data);
    uart_frame_t frame;
    frame.data   = data;
    frame.parity = odd_parity(data);
    return frame;
  endfunction

endpackage

// ==== source/uart_baud_timer.sv ====
`timescale 1ns/1ns

module uart_baud_timer #(
  parameter int CLK_FREQ = 50_000_000,
  parameter int BR       = 115200
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic restart,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int DIVISOR = CLK_FREQ / BR;
  localparam int CNT_W   = $clog2(DIVISOR);

  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(DIVISOR - 1);
  localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(DIVISOR / 2 - 1);

  logic [CNT_W-1:0] cnt;
  logic             counting;

  // A restart cycle starts a fresh bit period and gives no tick.
  assign counting = run && !restart;
  assign bit_tick = counting && (cnt == LAST_CNT);
  assign mid_tick = counting && (cnt == MID_CNT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!counting || cnt == LAST_CNT) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(bit_tick && mid_tick))
    else $error("bit_tick and mid_tick high together");

endmodule

// ==== source/uart_tx_shifter.sv ====
`timescale 1ns/1ns

module uart_tx_shifter import uart_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  uart_frame_t frame,
  input  logic        bit_tick,
  output logic        tx,
  output logic        done
);

  // The start bit goes straight to tx, the rest waits here.
  localparam int SHIFT_W = FRAME_BITS - 1;
  localparam int CNT_W   = $clog2(FRAME_BITS);

  logic [SHIFT_W-1:0] shift_q;
  logic [CNT_W-1:0]   bit_cnt;
  logic               busy;
  logic               last_bit;

  assign last_bit = bit_cnt == CNT_W'(FRAME_BITS - 1);

  // Ends with the stop bit, so a new start can follow without a gap.
  assign done = busy && bit_tick && last_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else if (start) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      tx      <= START_BIT;
    end else if (busy && bit_tick) begin
      if (last_bit) begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shift_q[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= {STOP_BIT, frame.parity, frame.data};
    end else if (busy && bit_tick) begin
      shift_q <= {STOP_BIT, shift_q[SHIFT_W-1:1]};
    end
  end

  // A new frame may only start once the current stop bit is over.
  assert property (@(posedge clk) disable iff (!rst_n) start |-> (!busy || done))
    else $error("tx start while a frame is in flight");

endmodule

// ==== source/uart_rx_sampler.sv ====
`timescale 1ns/1ns

module uart_rx_sampler import uart_pkg::*; #(
  parameter int CHEAK = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic        rx,
  input  logic        mid_tick,
  output logic        restart,
  output uart_frame_t frame,
  output logic        error,
  output logic        done
);

  localparam int IDX_W = $clog2(FRAME_BITS);

  localparam logic [IDX_W-1:0] PARITY_IDX = IDX_W'(DATA_BITS + 1);
  localparam logic [IDX_W-1:0] STOP_IDX   = IDX_W'(FRAME_BITS - 1);

  // Two synchronising flops plus one of history for edge detection.
  logic [2:0]           rx_sync;
  logic                 rx_s;
  logic                 rx_fall;
  logic                 busy;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_BITS-1:0] data_q;
  logic                 parity_q;
  logic                 parity_bad;
  logic                 data_bit;

  assign rx_s    = rx_sync[1];
  assign rx_fall = rx_sync[2] && !rx_sync[1];

  // Realigns the shared timer so mid_tick lands mid-bit.
  assign restart = enable && !busy && rx_fall;

  assign data_bit = (bit_idx >= IDX_W'(1)) && (bit_idx <= IDX_W'(DATA_BITS));

  // Valid on the stop-bit sample, with the stop bit still on rx_s.
  assign done       = busy && mid_tick && (bit_idx == STOP_IDX);
  assign parity_bad = (CHEAK != 0) && (parity_q != odd_parity(data_q));
  assign error      = (rx_s != STOP_BIT) || parity_bad;
  assign frame      = '{data: data_q, parity: parity_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_idx <= '0;
    end else if (!enable) begin
      busy <= 1'b0;
    end else if (restart) begin
      busy    <= 1'b1;
      bit_idx <= '0;
    end else if (busy && mid_tick) begin
      if (bit_idx == '0 && rx_s != START_BIT) begin
        // Glitch, not a real start bit.
        busy <= 1'b0;
      end else if (bit_idx == STOP_IDX) begin
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // LSB arrives first.
  always_ff @(posedge clk) begin
    if (busy && mid_tick) begin
      if (data_bit) begin
        data_q <= {rx_s, data_q[DATA_BITS-1:1]};
      end
      if (bit_idx == PARITY_IDX) begin
        parity_q <= rx_s;
      end
    end
  end

endmodule

// ==== source/uart_cmd_ctrl.sv ====
`timescale 1ns/1ns

module uart_cmd_ctrl import uart_pkg::*; #(
  parameter int CMD_WIDTH  = 16,
  parameter int READ_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 timer_run,
  output logic                 timer_restart,
  output uart_frame_t          tx_frame,
  output logic                 tx_start,
  input  logic                 tx_done,
  input  logic                 rx_restart,
  output logic                 rx_enable,
  input  uart_frame_t          rx_frame,
  input  logic                 rx_error,
  input  logic                 rx_done,
  output logic                 read_rdy,
  output logic [READ_WIDTH:0]  read_data
);

  ctrl_state_e          state;
  cmd_op_e              op;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic                 first_q;
  logic                 accept;

  assign accept  = cmd_vld && cmd_rdy;
  assign op      = cmd_op_e'(cmd_q[CMD_WIDTH-1]);
  assign cmd_rdy = (state == ST_IDLE);

  assign timer_run = state inside {ST_SEND_HI, ST_SEND_LO, ST_WAIT_RX};
  // Only the first frame restarts the timer.
  assign timer_restart = first_q || rx_restart;
  assign rx_enable     = (state == ST_WAIT_RX);

  // High byte on the first cycle of ST_SEND_HI, low byte right as it ends.
  assign tx_start = (state == ST_SEND_HI) && (first_q || tx_done);
  assign tx_frame = make_frame(first_q ? cmd_q[CMD_WIDTH-1 -: DATA_BITS]
                                       : cmd_q[DATA_BITS-1:0]);

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      first_q   <= 1'b0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      first_q  <= accept;
      read_rdy <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_SEND_HI;
          end
        end
        ST_SEND_HI: begin
          if (tx_done) begin
            state <= ST_SEND_LO;
          end
        end
        ST_SEND_LO: begin
          if (tx_done) begin
            state <= (op == OP_READ) ? ST_WAIT_RX : ST_DONE;
          end
        end
        ST_WAIT_RX: begin
          if (rx_done) begin
            read_data <= {rx_error, READ_WIDTH'(rx_frame.data)};
            read_rdy  <= 1'b1;
            state     <= ST_DONE;
          end
        end
        ST_DONE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // A frame that has just started is still tracked by a send state.
  assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |=> state inside {ST_SEND_HI, ST_SEND_LO})
    else $error("tx_start not followed by a send state");

  // The opcode captured at acceptance must still be a read when data returns.
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> op == OP_READ)
    else $error("read_rdy for a write command");

endmodule

// ==== source/uart.sv ====
`timescale 1ns/1ns

module uart import uart_pkg::*; #(
  parameter int CLK_FREQ   = 50_000_000,
  parameter int BR         = 115200,
  parameter int CHEAK      = 1,
  parameter int CMD_WIDTH  = 16,
  parameter int READ_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  input  logic                 rx,
  output logic                 tx,
  output logic                 read_rdy,
  output logic [READ_WIDTH:0]  read_data,
  output logic                 cmd_rdy
);

  logic        timer_run;
  logic        timer_restart;
  logic        bit_tick;
  logic        mid_tick;
  uart_frame_t tx_frame;
  logic        tx_start;
  logic        tx_done;
  logic        rx_restart;
  logic        rx_enable;
  uart_frame_t rx_frame;
  logic        rx_error;
  logic        rx_done;

  uart_cmd_ctrl #(
    .CMD_WIDTH  (CMD_WIDTH),
    .READ_WIDTH (READ_WIDTH)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .timer_run     (timer_run),
    .timer_restart (timer_restart),
    .tx_frame      (tx_frame),
    .tx_start      (tx_start),
    .tx_done       (tx_done),
    .rx_restart    (rx_restart),
    .rx_enable     (rx_enable),
    .rx_frame      (rx_frame),
    .rx_error      (rx_error),
    .rx_done       (rx_done),
    .read_rdy      (read_rdy),
    .read_data     (read_data)
  );

  // Shared by both directions; the controller never overlaps them.
  uart_baud_timer #(
    .CLK_FREQ (CLK_FREQ),
    .BR       (BR)
  ) u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (timer_run),
    .restart  (timer_restart),
    .bit_tick (bit_tick),
    .mid_tick (mid_tick)
  );

  uart_tx_shifter u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (tx_start),
    .frame    (tx_frame),
    .bit_tick (bit_tick),
    .tx       (tx),
    .done     (tx_done)
  );

  uart_rx_sampler #(
    .CHEAK (CHEAK)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (rx_enable),
    .rx       (rx),
    .mid_tick (mid_tick),
    .restart  (rx_restart),
    .frame    (rx_frame),
    .error    (rx_error),
    .done     (rx_done)
  );

endmodule

// ==== bench/uart_checker.sv ====
`timescale 1ns/1ns

module uart_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  input  logic        cmd_rdy,
  input  logic        tx,
  input  logic        read_rdy,
  input  logic [8:0]  read_data,
  input  logic [9:0]  resp_word,
  output logic        read_req,
  output int          error_count,
  output int          frame_count,
  output int          read_count
);

  int   reads_taken;
  logic active = 1'b0;

  // Wire order from bit 0: start, data LSB first, odd parity, stop.
  function automatic logic [10:0] expected_frame(input logic [7:0] data);
    return {1'b1, ~^data, data, 1'b0};
  endfunction

  // Response word is {low stop, flipped parity, byte}.
  function automatic logic [8:0] expected_read(input logic [9:0] word);
    return {word[9] | word[8], word[7:0]};
  endfunction

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
      error_count++;
    end
  endtask

  // Finds the start edge, then samples every bit at its middle.
  task automatic check_frame(input logic [7:0] data, input int max_wait);
    logic [10:0] got;
    int          waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (tx !== 1'b0 && waited < max_wait);
    if (tx !== 1'b0) begin
      $display("Error: no start bit on tx within %0d cycles at %0t", max_wait, $time);
      error_count++;
    end else begin
      repeat (4) @(negedge clk);
      got[0] = tx;
      for (int i = 1; i < 11; i++) begin
        repeat (10) @(negedge clk);
        got[i] = tx;
      end
      frame_count++;
      compare_value("tx frame", expected_frame(data), got);
    end
  endtask

  initial begin : tx_decode
    logic [15:0] cmd;
    read_req = 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    compare_value("tx", 1, tx);
    compare_value("cmd_rdy", 1, cmd_rdy);
    compare_value("read_rdy", 0, read_rdy);
    compare_value("read_data", 0, read_data);
    forever begin
      @(negedge clk);
      if (rst_n === 1'b1 && cmd_vld === 1'b1 && cmd_rdy === 1'b1) begin
        cmd    = cmd_in;
        active = 1'b1;
        // High byte first, the low byte follows straight after its stop bit.
        check_frame(cmd[15:8], 2);
        check_frame(cmd[7:0], 6);
        active = 1'b0;
        if (cmd[15]) begin
          reads_taken++;
          read_req = ~read_req;
        end
      end
    end
  end

  // Between commands tx idles high, and read_rdy only answers a read.
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (!active && tx !== 1'b1) begin
        $display("Error: tx left idle with no command accepted at %0t", $time);
        error_count++;
      end
      if (read_rdy === 1'b1 && read_count >= reads_taken) begin
        $display("Error: read_rdy pulse with no read outstanding at %0t", $time);
        error_count++;
      end else if (read_rdy === 1'b1) begin
        compare_value("read_data", expected_read(resp_word), read_data);
        read_count++;
      end
    end
  end

endmodule

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ns

module uart_tb;

  localparam int NUM_CMDS   = 40;
  localparam int MAX_CYCLES = NUM_CMDS * 400 + 200;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  logic [8:0]  read_data;
  logic        cmd_rdy;

  logic [31:0] seed;
  logic [9:0]  resp_q[$];
  int          gap_q[$];
  logic [9:0]  resp_word;
  logic        read_req;
  int          error_count;
  int          frame_count;
  int          read_count;
  int          reads_sent = 0;
  int          cycles = 0;

  // Ten clocks per bit.
  uart #(.CLK_FREQ(50_000_000), .BR(5_000_000), .CHEAK(1)) u_uart (.*);

  uart_checker u_checker (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // With hold set, cmd_vld stays high while the DUT is busy, so the command
  // lands on the cycle cmd_rdy rises.
  task automatic issue_command(input logic [15:0] cmd, input logic hold);
    logic taken;
    taken = 1'b0;
    if (!hold) begin
      do begin
        @(negedge clk);
      end while (cmd_rdy !== 1'b1);
    end
    while (!taken) begin
      @(posedge clk);
      cmd_in  <= cmd;
      cmd_vld <= 1'b1;
      @(negedge clk);
      taken = (cmd_rdy === 1'b1);
    end
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // Start, data LSB first, parity and stop, ten clocks each.
  task automatic send_response(input logic [9:0] word, input int gap);
    logic [10:0] bits;
    bits      = {~word[9], (~^word[7:0]) ^ word[8], word[7:0], 1'b0};
    resp_word <= word;
    repeat (gap + 1) @(posedge clk);
    for (int i = 0; i < 11; i++) begin
      rx <= bits[i];
      repeat (10) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic end_run(input logic timed_out);
    int total;
    total = error_count;
    if (timed_out) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      total++;
    end else if (read_count != reads_sent) begin
      $display("Error: %0d read commands sent but %0d read_rdy pulses seen",
               reads_sent, read_count);
      total++;
    end
    $display("Errors: %0d, frames checked: %0d, reads checked: %0d",
             total, frame_count, read_count);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin : stimulus
    seed      = 32'd52;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    resp_word = '0;
    // Every fifth response gets a flipped parity, every seventh a low stop bit.
    for (int i = 0; i < NUM_CMDS; i++) begin
      seed = lcg_next(seed);
      resp_q.push_back({(i % 7 == 6), (i % 5 == 4), seed[23:16]});
      gap_q.push_back(int'(seed[31:24]) % 31);
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_CMDS; i++) begin
      seed = lcg_next(seed);
      if (seed[23]) begin
        reads_sent++;
      end
      issue_command(seed[23:8], seed[28]);
    end
    do begin
      @(negedge clk);
    end while (cmd_rdy !== 1'b1);
    repeat (20) @(negedge clk);
    end_run(1'b0);
  end

  // Remote device: answers each read command once its second frame is on tx.
  initial begin : responder
    @(posedge rst_n);
    forever begin
      @(read_req);
      repeat (7) @(negedge clk);
      send_response(resp_q.pop_front(), gap_q.pop_front());
    end
  end

  initial begin : watchdog
    wait (cycles >= MAX_CYCLES);
    end_run(1'b1);
  end

endmodule

// ==== flist.f ====
source/uart_pkg.sv
source/uart_baud_timer.sv
source/uart_tx_shifter.sv
source/uart_rx_sampler.sv
source/uart_cmd_ctrl.sv
source/uart.sv
bench/uart_checker.sv
bench/uart_tb.sv
